//--- src.f
+incdir+source
source/memmap_pkg.sv
source/host_pkg.sv
source/region_decode.sv
source/byte_lane_ram.sv
source/mem_array.sv
source/host_bridge.sv
source/ti_mem_top.sv
tb/ti_mem_sva.sv
tb/ti_mem_tb.sv

//--- tb/ti_mem_tb.sv
/*
  ti memory subsystem testbench
  cpu and host stimulus against a byte shadow model, checked by
  concurrent assertions, with a watchdog
*/

`timescale 1ns/1ps
`include "ti_mem_params.svh"

module ti_mem_tb;
  import memmap_pkg::*;
  import host_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam logic [31:0] HOST_WIN = 32'h0001_8000;  // gext word 0x00c000
  // ==============================
  // watchdog budget, cycles per test
  // ==============================
  localparam int LANES_CYC = 120;
  localparam int FOLD_CYC  = 20;
  localparam int ROM_CYC   = 40;
  localparam int UNMAP_CYC = 40;
  localparam int LOAD_CYC  = 400;  // 48 host requests under load
  localparam int WATCHDOG_CYC = 2 * (LANES_CYC + FOLD_CYC + ROM_CYC + UNMAP_CYC + LOAD_CYC)
                                + 10 + 100;  // reset plus margin

  logic        clk;
  logic        i_reset;
  cpu_req_t    cpu;
  host_req_t   host_req;
  logic [15:0] cpu_rdata;
  logic        cpu_rvalid;
  host_rsp_t   host_rsp;
  logic        host_credit;
  logic [7:0]  cpu_control;

  logic [7:0]  shadow [int];    // byte model, keyed by region and offset
  logic [15:0] cpu_exp;         // expected word of the read on the bus
  logic [15:0] cpu_exp_q;
  logic [7:0]  exp_mem [0:255]; // expected host bytes, in order
  logic [7:0]  exp_head;
  int          exp_wr = 0;
  int          exp_rd = 0;
  int          sent_cnt = 0;
  int          ret_cnt = 0;
  int          credits_now;
  logic [7:0]  ctrl_exp = 8'h00;
  logic        ctrl_check;
  logic        credit_check;
  logic [31:0] cpu_rng  = 32'h7b3a_8123;
  logic [31:0] host_rng = 32'h7b3a_8123 ^ 32'h5555_aaaa;  // separate stream
  int          errors = 0;
  int          tests_run = 0;
  int          tests_passed = 0;
  int          errs_before;
  logic        traffic_done;
  string       test_name = "reset";

  ti_mem_top ti_mem_top_i
  (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_cpu         (cpu),
    .i_host_req    (host_req),
    .o_cpu_rdata   (cpu_rdata),
    .o_cpu_rvalid  (cpu_rvalid),
    .o_host_rsp    (host_rsp),
    .o_host_credit (host_credit),
    .o_cpu_control (cpu_control)
  );

  bind ti_mem_top ti_mem_sva sva_i
  (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_cpu         (i_cpu),
    .i_host_req    (i_host_req),
    .i_cpu_rvalid  (o_cpu_rvalid),
    .i_host_rsp    (o_host_rsp),
    .i_host_credit (o_host_credit),
    .i_cpu_control (o_cpu_control)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  assign exp_head    = exp_mem[exp_rd[7:0]];
  assign credits_now = `TI_HOST_CREDITS - (sent_cnt - ret_cnt);

  always @(posedge clk)
  begin
    cpu_exp_q <= cpu_exp;
    if (!i_reset && host_rsp.valid)
    begin
      exp_rd <= exp_rd + 1;  // one expected byte per response
    end
    if (!i_reset && host_credit)
    begin
      ret_cnt <= ret_cnt + 1;
    end
  end

  // ==============================
  // checks
  // ==============================
  cpu_data_chk: assert property (@(posedge clk) disable iff (i_reset)
    (cpu.valid && !cpu.we) |=> (cpu_rdata === cpu_exp_q))
  else
  begin
    $error("error %s: cpu read expected %h actual %h", test_name, $sampled(cpu_exp_q),
           $sampled(cpu_rdata));
    errors++;
  end

  host_rsp_expected: assert property (@(posedge clk) disable iff (i_reset)
    host_rsp.valid |-> (exp_rd < exp_wr))
  else
  begin
    $error("%s: host response arrived with no request waiting for it", test_name);
    errors++;
  end

  host_data_chk: assert property (@(posedge clk) disable iff (i_reset)
    host_rsp.valid |-> (host_rsp.data === exp_head))
  else
  begin
    $error("error %s: host byte expected %h actual %h", test_name, $sampled(exp_head),
           $sampled(host_rsp.data));
    errors++;
  end

  ctrl_chk: assert property (@(posedge clk) ctrl_check |-> (cpu_control === ctrl_exp))
  else
  begin
    $error("error %s: control expected %h actual %h", test_name, $sampled(ctrl_exp),
           $sampled(cpu_control));
    errors++;
  end

  credit_chk: assert property (@(posedge clk)
    credit_check |-> (credits_now == `TI_HOST_CREDITS))
  else
  begin
    $error("error %s: credits expected %0d actual %0d", test_name, `TI_HOST_CREDITS,
           $sampled(credits_now));
    errors++;
  end

  // ==============================
  // shadow model, map rules
  // ==============================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] cpu_rand_next();
    cpu_rng = xorshift32(cpu_rng);
    return cpu_rng;
  endfunction

  function automatic logic [31:0] host_rand_next();
    host_rng = xorshift32(host_rng);
    return host_rng;
  endfunction

  // region code in the upper bits, lane in bit 0, -1 when unmapped
  function automatic int byte_key(input logic [22:0] wa, input logic lo);
    int base;
    if (wa <= 23'h000FFF)
      base = 32'h10000 + int'(wa);                    // rom
    else if (wa >= 23'h004000 && wa <= 23'h0041FF)
      base = 32'h20000 + int'(wa) - 'h4000;          // scratchpad
    else if (wa[22:15] == 8'd1 && wa[14:12] >= 3'd3 && wa[14:12] <= 3'd6)
      base = 32'h30000 + int'(wa[13:0]);             // grom extension
    else if (wa >= 23'h001000 && wa <= 23'h001FFF)
      base = 32'h40000 + int'(wa) - 'h1000;          // ram expansion low
    else if (wa >= 23'h005000 && wa <= 23'h007FFF)
      base = 32'h40000 + int'(wa) - 'h4000;          // ram expansion high
    else
      return -1;
    return (base << 1) | int'(lo);
  endfunction

  function automatic logic [7:0] shadow_byte(input int key);
    if (key < 0)
      return 8'h00;  // unmapped reads zero
    if (shadow.exists(key))
      return shadow[key];
    return 8'hxx;
  endfunction

  function automatic logic [15:0] expect_word(input logic [22:0] wa);
    return {shadow_byte(byte_key(wa, 1'b0)), shadow_byte(byte_key(wa, 1'b1))};
  endfunction

  // ==============================
  // drivers, falling edge
  // ==============================
  task cpu_write(input logic [22:0] wa, input logic ub, input logic lb,
                 input logic [15:0] d);
    int k;
    @(negedge clk);
    cpu = '{valid: 1'b1, we: 1'b1, ub: ub, lb: lb, addr: wa, wdata: d};
    k = byte_key(wa, 1'b0);
    if (k >= 0 && wa > 23'h000FFF)  // cpu cannot write rom
    begin
      if (ub)
        shadow[k] = d[15:8];
      if (lb)
        shadow[k + 1] = d[7:0];
    end
  endtask

  task cpu_read(input logic [22:0] wa);
    @(negedge clk);
    cpu = '{valid: 1'b1, we: 1'b0, ub: 1'b1, lb: 1'b1, addr: wa, wdata: 16'h0000};
    cpu_exp = expect_word(wa);
  endtask

  task cpu_idle();
    @(negedge clk);
    cpu = '0;
  endtask

  // every lane pattern, read back after each write
  task lane_sweep(input logic [22:0] wa);
    int p;
    cpu_write(wa, 1'b1, 1'b1, cpu_rand_next());
    cpu_read(wa);
    for (p = 0; p < 4; p++)
    begin
      cpu_write(wa, p[1], p[0], cpu_rand_next());
      cpu_read(wa);
    end
  endtask

  task host_send(input host_op_e op, input logic [31:0] a, input logic [7:0] d);
    int k;
    logic [7:0] e;
    @(negedge clk);
    while (credits_now == 0)  // no credit, hold off
    begin
      host_req.valid = 1'b0;
      @(negedge clk);
    end
    host_req = '{valid: 1'b1, op: op, addr: a, data: d};
    sent_cnt++;
    e = 8'h00;
    if (a[31:24] == `TI_HOST_MEM_TAG)
    begin
      k = byte_key(a[23:1], a[0]);
      if (op == OP_WRITE && k >= 0)
        shadow[k] = d;  // host may fill rom
      else if (op == OP_READ)
        e = shadow_byte(k);
    end
    else if (a[31:24] == `TI_HOST_CTRL_TAG && op == OP_WRITE)
    begin
      ctrl_exp = d;
    end
    exp_mem[exp_wr[7:0]] = e;
    exp_wr++;
  endtask

  task host_stop();
    @(negedge clk);
    host_req.valid = 1'b0;
  endtask

  task wait_drain();
    @(negedge clk);
    while (exp_rd != exp_wr)
      @(negedge clk);
  endtask

  task pulse_ctrl_check();
    @(negedge clk);
    ctrl_check = 1'b1;
    @(negedge clk);
    ctrl_check = 1'b0;
  endtask

  task pulse_credit_check();
    @(negedge clk);
    credit_check = 1'b1;
    @(negedge clk);
    credit_check = 1'b0;
  endtask

  // ==============================
  // test bookkeeping
  // ==============================
  function automatic int total_errors();
    return errors + ti_mem_top_i.sva_i.fail_count;
  endfunction

  task start_test(input string name);
    test_name = name;
    errs_before = total_errors();
  endtask

  task end_test();
    int n;
    repeat (4) @(negedge clk);  // let the last checks fire
    n = total_errors() - errs_before;
    tests_run++;
    if (n == 0)
    begin
      tests_passed++;
      $display("test %s ok", test_name);
    end
    else
    begin
      $display("test %s failed with %0d errors", test_name, n);
    end
  endtask

  initial
  begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("timeout: run still busy after %0d cycles in test %s", WATCHDOG_CYC, test_name);
    $display(">>> FAIL");
    $finish;
  end

  // ==============================
  // test sequence
  // ==============================
  initial
  begin
    logic [31:0] r;
    int b;
    cpu = '0;
    host_req = '0;
    i_reset = 1'b1;
    ctrl_check = 1'b0;
    credit_check = 1'b0;
    cpu_exp = '0;
    traffic_done = 1'b0;
    repeat (10) @(negedge clk);
    i_reset = 1'b0;

    start_test("cpu_lanes");
    for (b = 0; b < 4; b++)
      lane_sweep(23'h004000 + b);  // pad words reused under load
    lane_sweep(23'h00B123);
    lane_sweep(23'h00EFFF);
    lane_sweep(23'h001234);
    lane_sweep(23'h006789);
    cpu_idle();
    end_test();

    start_test("ramx_fold");
    cpu_write(23'h001000, 1'b1, 1'b1, 16'h1111);
    cpu_write(23'h005000, 1'b1, 1'b1, 16'h5555);  // offset 0x1000
    cpu_read(23'h001000);
    cpu_read(23'h005000);
    cpu_write(23'h001FFF, 1'b1, 1'b1, 16'h1FFF);
    cpu_write(23'h007FFF, 1'b1, 1'b1, 16'h7FFF);
    cpu_read(23'h001FFF);
    cpu_read(23'h007FFF);
    cpu_read(23'h005000);
    cpu_idle();
    end_test();

    start_test("rom_host");
    for (b = 0; b < 4; b++)
      host_send(OP_WRITE, 32'h0000_0100 + b, 8'hC0 + b);  // words 0x80, 0x81
    host_stop();
    wait_drain();
    cpu_read(23'h000080);
    cpu_read(23'h000081);
    cpu_write(23'h000080, 1'b1, 1'b1, 16'hDEAD);  // dropped
    cpu_read(23'h000080);
    cpu_idle();
    host_send(OP_READ, 32'h0000_0100, 8'h00);
    host_send(OP_READ, 32'h0000_0103, 8'h00);
    host_stop();
    wait_drain();
    end_test();

    start_test("unmapped_ctrl");
    pulse_ctrl_check();  // reset value
    cpu_read(23'h002000);
    cpu_read(23'h004200);
    cpu_read(23'h400000);
    cpu_idle();
    host_send(OP_READ, 32'h1200_0010, 8'h00);
    host_send(OP_WRITE, 32'h1200_0011, 8'h77);
    host_send(OP_READ, 32'h0000_4000, 8'h00);  // word 0x002000
    host_send(OP_READ, 32'hFF00_0000, 8'h00);
    host_send(OP_WRITE, 32'hFF00_0000, 8'hA5);
    host_stop();
    wait_drain();
    pulse_ctrl_check();
    end_test();

    start_test("credits_load");
    fork
      begin
        for (b = 0; b < 16; b++)
        begin
          r = host_rand_next();
          host_send(OP_WRITE, HOST_WIN + b, r[7:0]);  // fill before reading
        end
        for (b = 0; b < 32; b++)
        begin
          r = host_rand_next();
          host_send(r[31] ? OP_WRITE : OP_READ, HOST_WIN + r[3:0], r[15:8]);
        end
        host_stop();
        traffic_done = 1'b1;
      end
      begin
        while (!traffic_done)
        begin
          if (cpu_rand_next() % 4 != 0)
            cpu_read(23'h004000 + cpu_rng[5:4]);  // busy about 3 in 4
          else
            cpu_idle();
        end
        cpu_idle();
      end
    join
    wait_drain();
    pulse_credit_check();
    end_test();

    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
             tests_run - tests_passed, total_errors());
    if (total_errors() == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- tb/ti_mem_sva.sv
/*
  ti memory protocol assertions
  cpu read timing, host credit bound, response and credit pairing,
  idle outputs after reset
*/

`timescale 1ns/1ps
`include "ti_mem_params.svh"

module ti_mem_sva
(
  input logic                 clk,
  input logic                 i_reset,
  input memmap_pkg::cpu_req_t i_cpu,
  input host_pkg::host_req_t  i_host_req,
  input logic                 i_cpu_rvalid,
  input host_pkg::host_rsp_t  i_host_rsp,
  input logic                 i_host_credit,
  input logic [7:0]           i_cpu_control
);
  import memmap_pkg::*;
  import host_pkg::*;

  int fail_count = 0;  // failed assertions so far
  int outstanding;     // host requests without a credit back

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      outstanding <= 0;
    end
    else
    begin
      outstanding <= outstanding + int'(i_host_req.valid) - int'(i_host_credit);
    end
  end

  // ==============================
  // cpu side
  // ==============================
  rvalid_after_read: assert property (@(posedge clk) disable iff (i_reset)
    (i_cpu.valid && !i_cpu.we) |=> i_cpu_rvalid)
  else
  begin
    $error("cpu read not followed by rvalid");
    fail_count++;
  end

  rvalid_only_after_read: assert property (@(posedge clk) disable iff (i_reset)
    i_cpu_rvalid |-> $past(i_cpu.valid && !i_cpu.we))
  else
  begin
    $error("rvalid without a cpu read one cycle before");
    fail_count++;
  end

  // ==============================
  // host side
  // ==============================
  // a credit that was never owed drives the count below zero
  credits_bounded: assert property (@(posedge clk) disable iff (i_reset)
    (outstanding >= 0) && (outstanding <= `TI_HOST_CREDITS))
  else
  begin
    $error("host credit count out of range, credit returned twice or too many requests");
    fail_count++;
  end

  rsp_with_credit: assert property (@(posedge clk) disable iff (i_reset)
    i_host_rsp.valid == i_host_credit)
  else
  begin
    $error("host response and credit pulse out of step");
    fail_count++;
  end

  // reset is synchronous, outputs clear one edge later
  idle_after_reset: assert property (@(posedge clk)
    i_reset |=> (!i_cpu_rvalid && !i_host_rsp.valid && !i_host_credit
                 && (i_cpu_control == 8'h00)))
  else
  begin
    $error("outputs active after reset");
    fail_count++;
  end

endmodule

//--- source/ti_mem_top.sv
/*
  ti memory subsystem top
  host loader bridge in front of the region memory array
*/

`timescale 1ns/1ps
`include "ti_mem_params.svh"

module ti_mem_top
(
  input  logic                  clk,
  input  logic                  i_reset,
  input  memmap_pkg::cpu_req_t  i_cpu,
  input  host_pkg::host_req_t   i_host_req,
  output logic [`TI_DATA_W-1:0] o_cpu_rdata,
  output logic                  o_cpu_rvalid,
  output host_pkg::host_rsp_t   o_host_rsp,
  output logic                  o_host_credit,
  output logic [7:0]            o_cpu_control
);
  import memmap_pkg::*;

  mem_req_t              host_mem;    // bridge to array
  logic [`TI_DATA_W-1:0] host_rdata;  // array to bridge

  // cpu bus is never stalled, any valid blocks the host
  host_bridge bridge_i
  (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_host_req    (i_host_req),
    .i_cpu_busy    (i_cpu.valid),
    .i_host_rdata  (host_rdata),
    .o_host_rsp    (o_host_rsp),
    .o_host_credit (o_host_credit),
    .o_host_mem    (host_mem),
    .o_cpu_control (o_cpu_control)
  );

  mem_array array_i
  (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_cpu        (i_cpu),
    .i_host_mem   (host_mem),
    .o_cpu_rdata  (o_cpu_rdata),
    .o_cpu_rvalid (o_cpu_rvalid),
    .o_host_rdata (host_rdata)
  );

endmodule

//--- source/host_bridge.sv
/*
  host bridge
  credit controlled in-order request queue for the host loader,
  byte to word conversion and the cpu control register
*/

`timescale 1ns/1ps
`include "ti_mem_params.svh"

module host_bridge
(
  input  logic                  clk,
  input  logic                  i_reset,
  input  host_pkg::host_req_t   i_host_req,
  input  logic                  i_cpu_busy,
  input  logic [`TI_DATA_W-1:0] i_host_rdata,
  output host_pkg::host_rsp_t   o_host_rsp,
  output logic                  o_host_credit,
  output memmap_pkg::mem_req_t  o_host_mem,
  output logic [7:0]            o_cpu_control
);
  import host_pkg::*;

  localparam int DEPTH = `TI_HOST_CREDITS;
  localparam int PW    = $clog2(DEPTH);

  // what answers in the cycle after a pop
  typedef enum logic [1:0]
  {
    PEND_IDLE = 2'd0,
    PEND_READ = 2'd1,  // byte from memory
    PEND_ZERO = 2'd2   // writes and non memory requests
  } pend_e;

  host_req_t     fifo_q [0:DEPTH-1];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  host_req_t     head;
  logic          head_ok;
  logic          head_mem;
  logic          head_ctrl;
  logic          issue;
  logic          pop;
  pend_e         pend_q;
  logic          pend_lo_q;  // odd byte, lower lane

  // ==============================
  // queue
  // ==============================
  // no full check, host credits bound the fill
  always_ff @(posedge clk)
  begin
    if (i_host_req.valid)
    begin
      fifo_q[wr_ptr] <= i_host_req;
    end
  end

  assign head      = fifo_q[rd_ptr];
  assign head_ok   = (count != '0);
  assign head_mem  = (head.addr[`TI_HOST_ADDR_W-1:24] == `TI_HOST_MEM_TAG);
  assign head_ctrl = (head.addr[`TI_HOST_ADDR_W-1:24] == `TI_HOST_CTRL_TAG)
                  && (head.op == OP_WRITE);
  assign issue     = head_ok && head_mem && !i_cpu_busy;  // cpu always wins
  assign pop       = issue || (head_ok && !head_mem);     // others skip memory

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      pend_q        <= PEND_IDLE;
      o_cpu_control <= 8'h00;
    end
    else
    begin
      if (i_host_req.valid)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {{PW{1'b0}}, i_host_req.valid} - {{PW{1'b0}}, pop};
      if (pop && issue && (head.op == OP_READ))
      begin
        pend_q <= PEND_READ;
      end
      else if (pop)
      begin
        pend_q <= PEND_ZERO;
      end
      else
      begin
        pend_q <= PEND_IDLE;
      end
      if (pop && head_ctrl)
      begin
        o_cpu_control <= head.data;  // top byte ff
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      pend_lo_q <= head.addr[0];
    end
  end

  // ==============================
  // memory side, byte to word
  // ==============================
  always_comb
  begin
    o_host_mem.req.valid = issue;
    o_host_mem.req.we    = (head.op == OP_WRITE);
    o_host_mem.req.ub    = !head.addr[0];  // even byte is the upper lane
    o_host_mem.req.lb    = head.addr[0];
    o_host_mem.req.addr  = head.addr[`TI_ADDR_W:1];
    o_host_mem.req.wdata = {head.data, head.data};  // both lanes, one enabled
    o_host_mem.host      = 1'b1;
  end

  // ==============================
  // response and credit return
  // ==============================
  always_comb
  begin
    o_host_rsp.valid = (pend_q != PEND_IDLE);
    o_host_rsp.data  = 8'h00;
    if (pend_q == PEND_READ)
    begin
      o_host_rsp.data = pend_lo_q ? i_host_rdata[7:0] : i_host_rdata[15:8];
    end
  end

  assign o_host_credit = (pend_q != PEND_IDLE);  // one credit per response

endmodule

//--- source/mem_array.sv
/*
  memory array
  merges cpu and host requests, gates region write enables and
  returns read data one cycle later through one multiplexer
*/

`timescale 1ns/1ps
`include "ti_mem_params.svh"

module mem_array
(
  input  logic                  clk,
  input  logic                  i_reset,
  input  memmap_pkg::cpu_req_t  i_cpu,
  input  memmap_pkg::mem_req_t  i_host_mem,
  output logic [`TI_DATA_W-1:0] o_cpu_rdata,
  output logic                  o_cpu_rvalid,
  output logic [`TI_DATA_W-1:0] o_host_rdata
);
  import memmap_pkg::*;

  mem_req_t              req;       // merged request
  region_e               region;
  region_e               region_q;  // selects the read mux
  logic [13:0]           offset;
  logic                  wr;
  logic                  wr_rom;
  logic                  wr_pad;
  logic                  wr_gext;
  logic                  wr_ramx;
  logic [`TI_DATA_W-1:0] rom_rdata;
  logic [`TI_DATA_W-1:0] pad_rdata;
  logic [`TI_DATA_W-1:0] gext_rdata;
  logic [`TI_DATA_W-1:0] ramx_rdata;
  logic [`TI_DATA_W-1:0] rdata;

  // ==============================
  // port merge, cpu first
  // ==============================
  always_comb
  begin
    if (i_cpu.valid)
    begin
      req.req  = i_cpu;
      req.host = 1'b0;
    end
    else
    begin
      req = i_host_mem;  // bridge only offers when cpu idle
    end
  end

  region_decode decode_i
  (
    .i_addr   (req.req.addr),
    .o_region (region),
    .o_offset (offset)
  );

  // ==============================
  // write gating
  // ==============================
  assign wr      = req.req.valid && req.req.we;
  assign wr_rom  = wr && (region == REG_ROM) && req.host;  // rom is read only to the cpu
  assign wr_pad  = wr && (region == REG_PAD);
  assign wr_gext = wr && (region == REG_GEXT);
  assign wr_ramx = wr && (region == REG_RAMX);

  byte_lane_ram #(.AW(`TI_ROM_AW)) rom_i
  (
    .clk     (clk),
    .i_we_hi (wr_rom && req.req.ub),
    .i_we_lo (wr_rom && req.req.lb),
    .i_addr  (offset[`TI_ROM_AW-1:0]),
    .i_wdata (req.req.wdata),
    .o_rdata (rom_rdata)
  );

  byte_lane_ram #(.AW(`TI_PAD_AW)) pad_i
  (
    .clk     (clk),
    .i_we_hi (wr_pad && req.req.ub),
    .i_we_lo (wr_pad && req.req.lb),
    .i_addr  (offset[`TI_PAD_AW-1:0]),
    .i_wdata (req.req.wdata),
    .o_rdata (pad_rdata)
  );

  byte_lane_ram #(.AW(`TI_GEXT_AW)) gext_i
  (
    .clk     (clk),
    .i_we_hi (wr_gext && req.req.ub),
    .i_we_lo (wr_gext && req.req.lb),
    .i_addr  (offset[`TI_GEXT_AW-1:0]),
    .i_wdata (req.req.wdata),
    .o_rdata (gext_rdata)
  );

  byte_lane_ram #(.AW(`TI_RAMX_AW)) ramx_i
  (
    .clk     (clk),
    .i_we_hi (wr_ramx && req.req.ub),
    .i_we_lo (wr_ramx && req.req.lb),
    .i_addr  (offset[`TI_RAMX_AW-1:0]),
    .i_wdata (req.req.wdata),
    .o_rdata (ramx_rdata)
  );

  // ==============================
  // read return
  // ==============================
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      region_q     <= REG_NONE;
      o_cpu_rvalid <= 1'b0;
    end
    else
    begin
      region_q     <= req.req.valid ? region : REG_NONE;  // idle reads zero
      o_cpu_rvalid <= i_cpu.valid && !i_cpu.we;
    end
  end

  always_comb
  begin
    case (region_q)
      REG_ROM:  rdata = rom_rdata;
      REG_PAD:  rdata = pad_rdata;
      REG_GEXT: rdata = gext_rdata;
      REG_RAMX: rdata = ramx_rdata;
      default:  rdata = '0;  // unmapped
    endcase
  end

  assign o_cpu_rdata  = rdata;
  assign o_host_rdata = rdata;  // host owns the cycle after its issue

endmodule

//--- source/byte_lane_ram.sv
/*
  byte lane ram
  single port, registered read, independent upper and lower lane writes
*/

`timescale 1ns/1ps
`include "ti_mem_params.svh"

module byte_lane_ram
#(
  parameter int AW = 12  // word address bits
)
(
  input  logic                  clk,
  input  logic                  i_we_hi,
  input  logic                  i_we_lo,
  input  logic [AW-1:0]         i_addr,
  input  logic [`TI_DATA_W-1:0] i_wdata,
  output logic [`TI_DATA_W-1:0] o_rdata
);

  localparam int LW    = `TI_DATA_W / 2;  // lane width
  localparam int WORDS = 1 << AW;

  logic [LW-1:0] mem_hi [0:WORDS-1];  // bits 15..8, even bytes
  logic [LW-1:0] mem_lo [0:WORDS-1];  // bits 7..0, odd bytes

  always_ff @(posedge clk)
  begin
    if (i_we_hi)
    begin
      mem_hi[i_addr] <= i_wdata[`TI_DATA_W-1:LW];
    end
    if (i_we_lo)
    begin
      mem_lo[i_addr] <= i_wdata[LW-1:0];
    end
    o_rdata <= {mem_hi[i_addr], mem_lo[i_addr]};  // read first
  end

endmodule

//--- source/region_decode.sv
/*
  region decode
  word address to region and local word offset, ram expansion
  folded so that no two windows share a word
*/

`timescale 1ns/1ps
`include "ti_mem_params.svh"

module region_decode
(
  input  logic [`TI_ADDR_W-1:0] i_addr,
  output memmap_pkg::region_e   o_region,
  output logic [13:0]           o_offset
);
  import memmap_pkg::*;

  logic rom_hit;
  logic pad_hit;
  logic gext_hit;
  logic ramx_lo_hit;
  logic ramx_hi_hit;

  // word address ranges, adr[14] is cpu a15
  assign rom_hit     = (i_addr[`TI_ADDR_W-1:12] == 11'h000);  // 0x000000..0x000fff
  assign pad_hit     = (i_addr[`TI_ADDR_W-1:9] == 14'h0020);  // 0x004000..0x0041ff
  assign gext_hit    = (i_addr[`TI_ADDR_W-1:15] == 8'h01)
                    && (i_addr[14:12] >= 3'd3) && (i_addr[14:12] <= 3'd6);
  assign ramx_lo_hit = (i_addr[`TI_ADDR_W-1:12] == 11'h001);  // 8K low window
  assign ramx_hi_hit = (i_addr[`TI_ADDR_W-1:15] == 8'h00)
                    && (i_addr[14:12] >= 3'd5);              // 0x005000..0x007fff

  always_comb
  begin
    o_region = REG_NONE;
    o_offset = '0;
    if (rom_hit)
    begin
      o_region = REG_ROM;
      o_offset = {2'b00, i_addr[11:0]};
    end
    else if (pad_hit)
    begin
      o_region = REG_PAD;
      o_offset = {5'b0_0000, i_addr[8:0]};
    end
    else if (gext_hit)
    begin
      o_region = REG_GEXT;
      o_offset = i_addr[13:0];  // 3..6 land on distinct 4K blocks
    end
    else if (ramx_lo_hit)
    begin
      o_region = REG_RAMX;
      o_offset = {2'b00, i_addr[11:0]};  // offset 0x0000..0x0fff
    end
    else if (ramx_hi_hit)
    begin
      o_region = REG_RAMX;
      o_offset = i_addr[13:0];  // minus 0x4000, just drops bit 14
    end
  end

endmodule

//--- source/host_pkg.sv
/*
  host loader types
  byte wide requests and responses of the loader port
*/

`include "ti_mem_params.svh"

package host_pkg;

  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } host_op_e;

  // one byte per request, top address byte picks the target
  typedef struct packed
  {
    logic                       valid;
    host_op_e                   op;
    logic [`TI_HOST_ADDR_W-1:0] addr;
    logic [7:0]                 data;
  } host_req_t;

  // writes answer with data zero
  typedef struct packed
  {
    logic       valid;
    logic [7:0] data;
  } host_rsp_t;

endpackage

//--- source/memmap_pkg.sv
/*
  memory map types
  region codes and the 16-bit cpu bus request
*/

`include "ti_mem_params.svh"

package memmap_pkg;

  // ==============================
  // regions
  // ==============================
  typedef enum logic [2:0]
  {
    REG_NONE = 3'd0,  // unmapped, reads zero
    REG_ROM  = 3'd1,  // system rom, host fills it
    REG_PAD  = 3'd2,  // scratchpad
    REG_GEXT = 3'd3,  // cartridge grom extension
    REG_RAMX = 3'd4   // 32K ram expansion
  } region_e;

  // ==============================
  // cpu bus
  // ==============================
  // strobes active high here, the tms9900 side had them low
  typedef struct packed
  {
    logic                  valid;
    logic                  we;
    logic                  ub;     // upper lane, bits 15..8
    logic                  lb;     // lower lane, bits 7..0
    logic [`TI_ADDR_W-1:0] addr;   // word address
    logic [`TI_DATA_W-1:0] wdata;
  } cpu_req_t;

  // merged request into the array
  typedef struct packed
  {
    cpu_req_t req;
    logic     host;  // host loader access, may write rom
  } mem_req_t;

endpackage

//--- source/ti_mem_params.svh
/*
  ti memory subsystem parameters
  bus widths, region depths, host tags and credit count
*/

`ifndef TI_MEM_PARAMS_SVH
`define TI_MEM_PARAMS_SVH

// ==============================
// cpu bus
// ==============================
`define TI_ADDR_W        23     // cpu word address
`define TI_DATA_W        16

// ==============================
// host loader port
// ==============================
`define TI_HOST_ADDR_W   32     // byte address, top byte is the tag
`define TI_HOST_CREDITS  4      // also the queue depth
`define TI_HOST_MEM_TAG  8'h00  // memory window
`define TI_HOST_CTRL_TAG 8'hFF  // cpu control register

// ==============================
// region depths, word address bits
// ==============================
`define TI_ROM_AW        12     // 8K bytes system rom
`define TI_PAD_AW        9      // 1K bytes scratchpad
`define TI_GEXT_AW       14     // 32K bytes grom extension
`define TI_RAMX_AW       14     // 32K bytes ram expansion

`endif
